/* list.f */
source/rv_pkg.sv
source/rv_word_ram.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_hazard_unit.sv
source/rv_alu.sv
source/rv_core.sv
test/rv_checker.sv
test/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_word_ram.sv
  - source/rv_regfile.sv
  - source/rv_decode.sv
  - source/rv_hazard_unit.sv
  - source/rv_alu.sv
  - source/rv_core.sv
  - target: test
    files:
      - test/rv_checker.sv
      - test/tb_rv_core.sv

/* test/tb_rv_core.sv */
// tb_rv_core
// loads a test program, runs the pipeline to the exit ecall and reports

`timescale 1ns/1ps

module tb_rv_core;

  localparam int n_prog       = 35;
  localparam int halt_timeout = 500; // cycles allowed from run to halt
  localparam int done_timeout = 50;  // cycles allowed for the checker after halt

  localparam logic [6:0] op_imm_code = 7'b0010011;
  localparam logic [6:0] load_code   = 7'b0000011;
  localparam logic [31:0] ecall_word = 32'h0000_0073;

  logic                    clk;
  logic                    arst_n;
  logic                    run;
  logic                    imem_we;
  logic [rv_pkg::xlen-1:0] imem_addr;
  logic [rv_pkg::xlen-1:0] imem_wdata;
  logic                    is_halted;
  logic [rv_pkg::xlen-1:0] print_reg [0:31];

  logic [rv_pkg::xlen-1:0] program_mem [0:n_prog-1];
  logic [rv_pkg::xlen-1:0] expected [0:31];
  logic                    check_done;
  int unsigned             check_errors;
  int unsigned             timeout_errors;

  rv_core #(.imem_depth(64), .dmem_depth(64)) i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .is_halted  (is_halted),
    .print_reg  (print_reg)
  );

  rv_checker #(.settle_cycles(8)) i_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .is_halted   (is_halted),
    .print_reg   (print_reg),
    .expected    (expected),
    .done        (check_done),
    .error_count (check_errors)
  );

  // rv32i instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                         input int rd, input int rs1, input int rs2);
    return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                         input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
  endfunction

  function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011}; // sw
  endfunction

  task automatic build_tables();
    program_mem[0]  = i_type(op_imm_code, 3'b000, 1, 0, 5);        // addi x1, x0, 5
    program_mem[1]  = i_type(op_imm_code, 3'b000, 2, 0, -3);       // addi x2, x0, -3
    program_mem[2]  = r_type(7'b0000000, 3'b000, 3, 1, 2);         // add, waits on x2
    program_mem[3]  = r_type(7'b0100000, 3'b000, 4, 1, 2);         // sub
    program_mem[4]  = r_type(7'b0000000, 3'b111, 5, 1, 2);         // and
    program_mem[5]  = r_type(7'b0000000, 3'b110, 6, 1, 2);         // or
    program_mem[6]  = r_type(7'b0000000, 3'b100, 7, 1, 2);         // xor
    program_mem[7]  = r_type(7'b0000000, 3'b010, 8, 2, 1);         // slt -3 < 5
    program_mem[8]  = r_type(7'b0000000, 3'b010, 9, 1, 2);         // slt 5 < -3
    program_mem[9]  = i_type(op_imm_code, 3'b000, 10, 0, 4);       // shift amount
    program_mem[10] = r_type(7'b0000000, 3'b001, 11, 1, 10);       // sll
    program_mem[11] = r_type(7'b0100000, 3'b101, 12, 2, 10);       // sra of a negative
    program_mem[12] = r_type(7'b0000000, 3'b101, 13, 2, 10);       // srl
    program_mem[13] = i_type(op_imm_code, 3'b111, 14, 2, 'h0f0);   // andi
    program_mem[14] = i_type(op_imm_code, 3'b110, 15, 1, 'h100);   // ori
    program_mem[15] = i_type(op_imm_code, 3'b100, 16, 1, -1);      // xori as not
    program_mem[16] = i_type(op_imm_code, 3'b010, 18, 2, -2);      // slti
    program_mem[17] = i_type(op_imm_code, 3'b001, 19, 1, 3);       // slli
    program_mem[18] = i_type(op_imm_code, 3'b101, 20, 2, 28);      // srli
    program_mem[19] = i_type(op_imm_code, 3'b101, 21, 2, 'h401);   // srai by 1
    program_mem[20] = s_type(4, 0, 8);                             // sw x4, 8(x0)
    program_mem[21] = i_type(load_code, 3'b010, 22, 0, 8);         // lw x22, 8(x0)
    program_mem[22] = i_type(op_imm_code, 3'b000, 23, 22, 1);      // load-use
    program_mem[23] = s_type(23, 0, 16);                           // store data just written
    program_mem[24] = i_type(load_code, 3'b010, 24, 0, 16);
    program_mem[25] = i_type(op_imm_code, 3'b000, 28, 0, 1);
    program_mem[26] = i_type(load_code, 3'b010, 28, 0, 12);        // unwritten word
    program_mem[27] = i_type(op_imm_code, 3'b000, 0, 1, 7);        // write to x0
    program_mem[28] = i_type(op_imm_code, 3'b000, 17, 0, 1);
    program_mem[29] = ecall_word;                                  // x17 = 1, no halt
    program_mem[30] = i_type(op_imm_code, 3'b000, 25, 17, 2);
    program_mem[31] = i_type(op_imm_code, 3'b000, 17, 0, 10);
    program_mem[32] = ecall_word;                                  // exit
    program_mem[33] = i_type(op_imm_code, 3'b000, 26, 0, 99);      // must never retire
    program_mem[34] = i_type(op_imm_code, 3'b000, 27, 0, 55);

    for (int i = 0; i < 32; i++) begin
      expected[i] = '0;
    end
    expected[1]  = 32'h0000_0005;
    expected[2]  = 32'hffff_fffd;
    expected[3]  = 32'h0000_0002;
    expected[4]  = 32'h0000_0008;
    expected[5]  = 32'h0000_0005;
    expected[6]  = 32'hffff_fffd;
    expected[7]  = 32'hffff_fff8;
    expected[8]  = 32'h0000_0001;
    expected[10] = 32'h0000_0004;
    expected[11] = 32'h0000_0050;
    expected[12] = 32'hffff_ffff;
    expected[13] = 32'h0fff_ffff;
    expected[14] = 32'h0000_00f0;
    expected[15] = 32'h0000_0105;
    expected[16] = 32'hffff_fffa;
    expected[17] = 32'h0000_000a;
    expected[18] = 32'h0000_0001;
    expected[19] = 32'h0000_0028;
    expected[20] = 32'h0000_000f;
    expected[21] = 32'hffff_fffe;
    expected[22] = 32'h0000_0008;
    expected[23] = 32'h0000_0009;
    expected[24] = 32'h0000_0009;
    expected[25] = 32'h0000_0003;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    int unsigned cycles;
    arst_n         = 1'b0;
    run            = 1'b0;
    imem_we        = 1'b0;
    imem_addr      = '0;
    imem_wdata     = '0;
    timeout_errors = 0;
    build_tables();

    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // load imem while the core is idle
    for (int i = 0; i < n_prog; i++) begin
      imem_we    <= 1'b1;
      imem_addr  <= i;
      imem_wdata <= program_mem[i];
      @(posedge clk);
    end
    imem_we <= 1'b0;
    @(posedge clk);
    run <= 1'b1;

    cycles = 0;
    while (!is_halted && cycles < halt_timeout) begin
      @(negedge clk);
      cycles++;
    end

    if (!is_halted) begin
      $display("Timeout: the core did not halt within %0d cycles", halt_timeout);
      timeout_errors++;
    end else begin
      cycles = 0;
      while (!check_done && cycles < done_timeout) begin
        @(posedge clk);
        cycles++;
      end
      if (!check_done) begin
        $display("Timeout: the checker never compared the registers after the halt");
        timeout_errors++;
      end
    end

    $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* test/rv_checker.sv */
// rv_checker
// watches halt and the register view, compares with the expected registers

`timescale 1ns/1ps

module rv_checker #(
  parameter int settle_cycles = 8 // drain time after halt before comparing
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    is_halted,
  input  logic [rv_pkg::xlen-1:0] print_reg [0:31],
  input  logic [rv_pkg::xlen-1:0] expected [0:31],
  output logic                    done,
  output int unsigned             error_count
);

  logic        reset_checked;
  logic        halt_seen;
  int unsigned settle_count;

  initial begin
    reset_checked = 1'b0;
    halt_seen     = 1'b0;
    settle_count  = 0;
    done          = 1'b0;
    error_count   = 0;
  end

  task automatic check_reg(input int idx, input logic [rv_pkg::xlen-1:0] exp);
    if (print_reg[idx] !== exp) begin
      $display("Error at %0d ns: x%0d expected 0x%08h, got 0x%08h",
               $time, idx, exp, print_reg[idx]);
      error_count++;
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n) begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (is_halted !== 1'b0) begin
          $display("Error at %0d ns: is_halted is not low after reset", $time);
          error_count++;
        end
        for (int i = 0; i < 32; i++) begin
          check_reg(i, '0);
        end
      end

      if (halt_seen && is_halted !== 1'b1) begin
        $display("Error at %0d ns: is_halted dropped after the halt", $time);
        error_count++;
      end
      if (is_halted === 1'b1) halt_seen = 1'b1;

      // younger instructions would have retired by now
      if (halt_seen && !done) begin
        if (settle_count == settle_cycles) begin
          for (int i = 0; i < 32; i++) begin
            check_reg(i, expected[i]);
          end
          done = 1'b1;
        end else begin
          settle_count++;
        end
      end
    end
  end

endmodule

/* source/rv_core.sv */
// rv_core
// five-stage in-order rv32i pipeline, stall on raw hazards, halts on exit ecall

`timescale 1ns/1ps

module rv_core #(
  parameter int imem_depth = 64,
  parameter int dmem_depth = 64
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    run,
  input  logic                    imem_we,
  input  logic [rv_pkg::xlen-1:0] imem_addr,  // word index
  input  logic [rv_pkg::xlen-1:0] imem_wdata,
  output logic                    is_halted,
  output logic [rv_pkg::xlen-1:0] print_reg [0:31]
);

  localparam int xw = rv_pkg::xlen;
  localparam int rw = rv_pkg::reg_idx_w;

  logic [xw-1:0] pc;
  logic [xw-1:0] imem_rdata;
  logic [xw-1:0] if_id_inst;

  // decode stage
  logic            dec_wb_enable, dec_mem_read, dec_mem_write, dec_op2_imm;
  logic            dec_rs2_used, dec_is_ecall, dec_halt_req;
  rv_pkg::alu_op_e dec_alu_op;
  logic [xw-1:0]   dec_imm;
  logic [rw-1:0]   rs1_idx;
  logic [xw-1:0]   rs1_data, rs2_data;
  logic            stall;
  logic            halt_flush;
  logic            hold;

  // id/ex
  logic            id_ex_wb_enable, id_ex_mem_read, id_ex_mem_write, id_ex_halt;
  logic            id_ex_op2_imm;
  rv_pkg::alu_op_e id_ex_alu_op;
  logic [xw-1:0]   id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
  logic [rw-1:0]   id_ex_rd;
  logic [xw-1:0]   alu_b, alu_result;

  // ex/mem
  logic          ex_mem_wb_enable, ex_mem_mem_read, ex_mem_mem_write, ex_mem_halt;
  logic [xw-1:0] ex_mem_alu, ex_mem_rs2_data;
  logic [rw-1:0] ex_mem_rd;
  logic [xw-1:0] dmem_addr, dmem_rdata, wb_data;

  // mem/wb
  logic          mem_wb_wb_enable, mem_wb_halt;
  logic [rw-1:0] mem_wb_rd;
  logic [xw-1:0] mem_wb_data;

  // an exit ecall in flight stops issue so nothing younger retires
  assign halt_flush = is_halted || id_ex_halt || ex_mem_halt || mem_wb_halt;
  assign hold       = stall || halt_flush;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) pc <= '0;
    else if (run && !hold) pc <= pc + 32'd4;
  end

  rv_word_ram #(.depth(imem_depth)) i_imem (
    .clk   (clk),
    .we    (imem_we),
    .waddr (imem_addr),
    .wdata (imem_wdata),
    .raddr ({2'b00, pc[xw-1:2]}),
    .rdata (imem_rdata)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) if_id_inst <= '0;
    else if (!hold) if_id_inst <= run ? imem_rdata : '0; // zero word is a bubble
  end

  rv_decode i_decode (
    .inst      (if_id_inst),
    .rs1_data  (rs1_data),
    .wb_enable (dec_wb_enable),
    .mem_read  (dec_mem_read),
    .mem_write (dec_mem_write),
    .op2_imm   (dec_op2_imm),
    .rs2_used  (dec_rs2_used),
    .is_ecall  (dec_is_ecall),
    .halt_req  (dec_halt_req),
    .alu_op    (dec_alu_op),
    .imm       (dec_imm)
  );

  assign rs1_idx = dec_is_ecall ? rv_pkg::ecall_reg[rw-1:0] : if_id_inst[19:15];

  rv_regfile i_regfile (
    .clk       (clk),
    .arst_n    (arst_n),
    .rs1       (rs1_idx),
    .rs2       (if_id_inst[24:20]),
    .rd        (mem_wb_rd),
    .rd_din    (mem_wb_data),
    .we        (mem_wb_wb_enable),
    .rs1_dout  (rs1_data),
    .rs2_dout  (rs2_data),
    .print_reg (print_reg)
  );

  rv_hazard_unit i_hazard (
    .rs1_id   (rs1_idx),
    .rs2_id   (if_id_inst[24:20]),
    .rs2_used (dec_rs2_used),
    .ex_we    (id_ex_wb_enable),
    .mem_we   (ex_mem_wb_enable),
    .ex_rd    (id_ex_rd),
    .mem_rd   (ex_mem_rd),
    .stall    (stall)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex_wb_enable <= 1'b0;
      id_ex_mem_read  <= 1'b0;
      id_ex_mem_write <= 1'b0;
      id_ex_halt      <= 1'b0;
    end else begin
      id_ex_wb_enable <= dec_wb_enable && !hold; // bubble on stall or halt
      id_ex_mem_read  <= dec_mem_read && !hold;
      id_ex_mem_write <= dec_mem_write && !hold;
      id_ex_halt      <= dec_halt_req && !hold;
    end
  end

  always_ff @(posedge clk) begin
    id_ex_op2_imm  <= dec_op2_imm;
    id_ex_alu_op   <= dec_alu_op;
    id_ex_rs1_data <= rs1_data;
    id_ex_rs2_data <= rs2_data;
    id_ex_imm      <= dec_imm;
    id_ex_rd       <= if_id_inst[11:7];
  end

  assign alu_b = id_ex_op2_imm ? id_ex_imm : id_ex_rs2_data;

  rv_alu i_alu (
    .alu_op (id_ex_alu_op),
    .a      (id_ex_rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem_wb_enable <= 1'b0;
      ex_mem_mem_read  <= 1'b0;
      ex_mem_mem_write <= 1'b0;
      ex_mem_halt      <= 1'b0;
    end else begin
      ex_mem_wb_enable <= id_ex_wb_enable;
      ex_mem_mem_read  <= id_ex_mem_read;
      ex_mem_mem_write <= id_ex_mem_write;
      ex_mem_halt      <= id_ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem_alu      <= alu_result;
    ex_mem_rs2_data <= id_ex_rs2_data;
    ex_mem_rd       <= id_ex_rd;
  end

  assign dmem_addr = {2'b00, ex_mem_alu[xw-1:2]}; // byte address to word index

  rv_word_ram #(.depth(dmem_depth)) i_dmem (
    .clk   (clk),
    .we    (ex_mem_mem_write),
    .waddr (dmem_addr),
    .wdata (ex_mem_rs2_data),
    .raddr (dmem_addr),
    .rdata (dmem_rdata)
  );

  assign wb_data = ex_mem_mem_read ? dmem_rdata : ex_mem_alu;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wb_wb_enable <= 1'b0;
      mem_wb_halt      <= 1'b0;
    end else begin
      mem_wb_wb_enable <= ex_mem_wb_enable;
      mem_wb_halt      <= ex_mem_halt;
    end
  end

  always_ff @(posedge clk) begin
    mem_wb_rd   <= ex_mem_rd;
    mem_wb_data <= wb_data;
  end

  // sticky until reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) is_halted <= 1'b0;
    else if (mem_wb_halt) is_halted <= 1'b1;
  end

  a_no_load_while_run : assert property (
    @(posedge clk) disable iff (!arst_n) !(imem_we && run))
    else $error("rv_core: instruction memory written while running");

endmodule

/* source/rv_alu.sv */
// rv_alu
// 32-bit alu, add sub logic slt and shifts

`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_e         alu_op,
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  output logic [rv_pkg::xlen-1:0] result
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // shift amount from low bits only

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add: result = a + b;
      rv_pkg::alu_sub: result = a - b;
      rv_pkg::alu_and: result = a & b;
      rv_pkg::alu_or:  result = a | b;
      rv_pkg::alu_xor: result = a ^ b;
      rv_pkg::alu_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_pkg::alu_sll: result = a << shamt;
      rv_pkg::alu_srl: result = a >> shamt;
      rv_pkg::alu_sra: result = $unsigned($signed(a) >>> shamt);
      default:         result = '0;
    endcase
  end

endmodule

/* source/rv_hazard_unit.sv */
// rv_hazard_unit
// raw check of decode sources against ex and mem destinations, no forwarding

`timescale 1ns/1ps

module rv_hazard_unit (
  input  logic [rv_pkg::reg_idx_w-1:0] rs1_id,
  input  logic [rv_pkg::reg_idx_w-1:0] rs2_id,
  input  logic                         rs2_used,
  input  logic                         ex_we,
  input  logic                         mem_we,
  input  logic [rv_pkg::reg_idx_w-1:0] ex_rd,
  input  logic [rv_pkg::reg_idx_w-1:0] mem_rd,
  output logic                         stall
);

  logic rs1_busy;
  logic rs2_busy;

  // source waits on a write still in ex or mem
  function automatic logic pending(input logic [rv_pkg::reg_idx_w-1:0] rs);
    logic ex_hit;
    logic mem_hit;
    ex_hit  = ex_we && (ex_rd == rs);
    mem_hit = mem_we && (mem_rd == rs);
    return (rs != '0) && (ex_hit || mem_hit);
  endfunction

  assign rs1_busy = pending(rs1_id);            // rs1 always read, x17 on ecall
  assign rs2_busy = rs2_used && pending(rs2_id);
  assign stall    = rs1_busy || rs2_busy;

endmodule

/* source/rv_decode.sv */
// rv_decode
// control, alu op select, immediates and ecall halt check for the id stage

`timescale 1ns/1ps

module rv_decode (
  input  logic [rv_pkg::xlen-1:0] inst,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  output logic                    wb_enable,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic                    op2_imm,
  output logic                    rs2_used,
  output logic                    is_ecall,
  output logic                    halt_req,
  output rv_pkg::alu_op_e         alu_op,
  output logic [rv_pkg::xlen-1:0] imm
);

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic            funct7_b5; // selects sub and sra
  logic            known_op;

  assign opcode    = rv_pkg::opcode_e'(inst[6:0]);
  assign funct3    = inst[14:12];
  assign funct7_b5 = inst[30];

  always_comb begin
    wb_enable = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    op2_imm   = 1'b0;
    rs2_used  = 1'b0;
    is_ecall  = 1'b0;
    known_op  = 1'b1;
    case (opcode)
      rv_pkg::op: begin
        wb_enable = 1'b1;
        rs2_used  = 1'b1;
      end
      rv_pkg::op_imm: begin
        wb_enable = 1'b1;
        op2_imm   = 1'b1;
      end
      rv_pkg::load: begin
        wb_enable = 1'b1;
        mem_read  = 1'b1;
        op2_imm   = 1'b1;
      end
      rv_pkg::store: begin
        mem_write = 1'b1;
        op2_imm   = 1'b1;
        rs2_used  = 1'b1; // store data
      end
      rv_pkg::system: is_ecall = (funct3 == 3'b000) && (inst[31:20] == '0);
      default: known_op = 1'b0; // bubble or unsupported, all enables off
    endcase
  end

  // alu op, loads and stores fall through to add for the address
  always_comb begin
    alu_op = rv_pkg::alu_add;
    if (opcode == rv_pkg::op || opcode == rv_pkg::op_imm) begin
      case (funct3)
        3'b000:  alu_op = (opcode == rv_pkg::op && funct7_b5) ? rv_pkg::alu_sub
                                                               : rv_pkg::alu_add;
        3'b001:  alu_op = rv_pkg::alu_sll;
        3'b010:  alu_op = rv_pkg::alu_slt;
        3'b100:  alu_op = rv_pkg::alu_xor;
        3'b101:  alu_op = funct7_b5 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
        3'b110:  alu_op = rv_pkg::alu_or;
        3'b111:  alu_op = rv_pkg::alu_and;
        default: alu_op = rv_pkg::alu_add; // sltu not supported
      endcase
    end
  end

  assign imm = (opcode == rv_pkg::store) ? {{20{inst[31]}}, inst[31:25], inst[11:7]}
                                         : {{20{inst[31]}}, inst[31:20]};

  assign halt_req = is_ecall && (rs1_data == rv_pkg::halt_code);

  // all-zero word is the pipeline bubble
  always_comb begin
    if (inst != '0) begin
      a_known_opcode : assert final (known_op)
        else $error("rv_decode: unknown opcode %b", inst[6:0]);
    end
  end

endmodule

/* source/rv_regfile.sv */
// rv_regfile
// 32 x 32 register file, x0 tied to zero, same-cycle write bypass

`timescale 1ns/1ps

module rv_regfile (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [rv_pkg::reg_idx_w-1:0] rs1,
  input  logic [rv_pkg::reg_idx_w-1:0] rs2,
  input  logic [rv_pkg::reg_idx_w-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]      rd_din,
  input  logic                         we,
  output logic [rv_pkg::xlen-1:0]      rs1_dout,
  output logic [rv_pkg::xlen-1:0]      rs2_dout,
  output logic [rv_pkg::xlen-1:0]      print_reg [0:31]
);

  logic [rv_pkg::xlen-1:0] regs [0:31];
  logic                    wr_valid;
  logic                    rs1_hit;
  logic                    rs2_hit;

  assign wr_valid = we && (rd != '0); // x0 never written

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_valid) begin
      regs[rd] <= rd_din;
    end
  end

  // value retiring in wb is visible to decode this cycle
  assign rs1_hit  = wr_valid && (rd == rs1);
  assign rs2_hit  = wr_valid && (rd == rs2);
  assign rs1_dout = rs1_hit ? rd_din : regs[rs1];
  assign rs2_dout = rs2_hit ? rd_din : regs[rs2];

  assign print_reg = regs; // debug view

endmodule

/* source/rv_word_ram.sv */
// rv_word_ram
// word memory, combinational read and clocked write, for imem and dmem

`timescale 1ns/1ps

module rv_word_ram #(
  parameter int depth = 64
) (
  input  logic                    clk,
  input  logic                    we,
  input  logic [rv_pkg::xlen-1:0] waddr,
  input  logic [rv_pkg::xlen-1:0] wdata,
  input  logic [rv_pkg::xlen-1:0] raddr,
  output logic [rv_pkg::xlen-1:0] rdata
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;

  logic [rv_pkg::xlen-1:0] mem [0:depth-1];

  // power-up contents are zero
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (we && (waddr < depth)) mem[waddr[aw-1:0]] <= wdata;
  end

  assign rdata = (raddr < depth) ? mem[raddr[aw-1:0]] : '0; // out of range reads zero

  a_waddr_range : assert property (@(posedge clk) we |-> (waddr < depth))
    else $error("rv_word_ram: write to word %0d beyond depth %0d", waddr, depth);

endmodule

/* source/rv_pkg.sv */
// rv_pkg
// shared constants and enums for the five-stage rv32i pipeline

package rv_pkg;

  localparam int xlen      = 32; // datapath width
  localparam int reg_idx_w = 5;  // register index width

  // ecall convention: x17 holds the service code, 10 means exit
  localparam logic [xlen-1:0] ecall_reg = 32'd17;
  localparam logic [xlen-1:0] halt_code = 32'd10;

  // major opcodes in use
  typedef enum logic [6:0] {
    op     = 7'b0110011, // register-register alu
    op_imm = 7'b0010011, // register-immediate alu
    load   = 7'b0000011,
    store  = 7'b0100011,
    system = 7'b1110011  // ecall only
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_slt = 4'd5,
    alu_sll = 4'd6,
    alu_srl = 4'd7,
    alu_sra = 4'd8
  } alu_op_e;

endpackage
